//--- design/aimbot_settings.svh
`ifndef AIMBOT_SETTINGS_SVH
`define AIMBOT_SETTINGS_SVH

// Active frame size
// H_ACT must be even and at least 4
`define AIMBOT_H_ACT 16
`define AIMBOT_V_ACT 8

// Crosshair colour, RGB888 components
`define AIMBOT_MARK_R 8'hFF
`define AIMBOT_MARK_G 8'h00
`define AIMBOT_MARK_B 8'h00

`endif

//--- design/aimbot_pkg.sv
package aimbot_pkg;

    // One RGB565 camera word
    // Bytes arrive high first, colours are read by the marker
    typedef union packed {
        struct packed {
            logic [7:0] hi_byte;
            logic [7:0] lo_byte;
        } bytes;
        struct packed {
            logic [4:0] r5;
            logic [5:0] g6;
            logic [4:0] b5;
        } rgb;
    } pixel565_u;

endpackage : aimbot_pkg

//--- design/cam_pixel_reader.sv
`timescale 1ns/100ps
`include "aimbot_settings.svh"

module cam_pixel_reader
    import aimbot_pkg::*;
(
    input  logic                              i_clk      ,
    input  logic                              i_rst      ,
    input  logic                              i_vsync    ,
    input  logic                              i_href     ,
    input  logic [7:0]                        i_data     ,
    output logic                              o_pix_valid,
    output logic                              o_vsync_d  ,
    output logic                              o_line_err ,
    output pixel565_u                         o_pixel    ,
    output logic [$clog2(`AIMBOT_H_ACT)-1:0]  o_col      ,
    output logic [$clog2(`AIMBOT_V_ACT)-1:0]  o_row
);

    localparam int COL_W  = $clog2(`AIMBOT_H_ACT);
    localparam int ROW_W  = $clog2(`AIMBOT_V_ACT);
    localparam int BYTE_W = $clog2(2 * `AIMBOT_H_ACT) + 1;

    localparam logic [COL_W-1:0]  COL_LAST   = COL_W'(`AIMBOT_H_ACT - 1);
    localparam logic [BYTE_W-1:0] LINE_BYTES = BYTE_W'(2 * `AIMBOT_H_ACT);

    logic              href_d;
    logic              phase;
    logic [7:0]        hi_byte;
    logic [BYTE_W-1:0] byte_cnt;
    logic [COL_W-1:0]  col_cnt;
    logic [ROW_W-1:0]  row_cnt;
    logic              href_rise;
    logic              href_fall;

    assign href_rise = i_href & ~href_d;
    assign href_fall = ~i_href & href_d;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            href_d      <= 1'b0;
            phase       <= 1'b0;
            byte_cnt    <= '0;
            col_cnt     <= '0;
            row_cnt     <= '0;
            o_col       <= '0;
            o_row       <= '0;
            o_pix_valid <= 1'b0;
            o_vsync_d   <= 1'b0;
            o_line_err  <= 1'b0;
        end else begin
            href_d      <= i_href;
            o_vsync_d   <= i_vsync;
            o_pix_valid <= i_href & phase;
            phase       <= i_href ? ~phase : 1'b0;

            // Saturating count of bytes in the current line
            if (!i_href) begin
                byte_cnt <= '0;
            end else if (byte_cnt != '1) begin
                byte_cnt <= byte_cnt + 1'b1;
            end

            if (href_rise) begin
                col_cnt <= '0;
            end else if (i_href && phase) begin
                o_col <= col_cnt;
                o_row <= row_cnt;
                // Hold at last column on overlong lines
                if (col_cnt != COL_LAST) begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end

            if (i_vsync) begin
                row_cnt <= '0;
            end else if (href_fall) begin
                row_cnt <= row_cnt + 1'b1;
            end

            // Sticky until reset
            if (href_fall && byte_cnt != LINE_BYTES) begin
                o_line_err <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_href && !phase) begin
            hi_byte <= i_data;
        end
        if (i_href && phase) begin
            o_pixel.bytes.hi_byte <= hi_byte;
            o_pixel.bytes.lo_byte <= i_data;
        end
    end

    a_href_outside_vsync : assert property (
        @(posedge i_clk) disable iff (i_rst) $rose(i_href) |-> !i_vsync);

    // True column of each pixel stays inside the active line
    a_col_in_range : assert property (
        @(posedge i_clk) disable iff (i_rst) o_pix_valid |-> (byte_cnt <= LINE_BYTES));

endmodule : cam_pixel_reader

//--- design/frame_marker.sv
`timescale 1ns/100ps
`include "aimbot_settings.svh"

module frame_marker
    import aimbot_pkg::*;
(
    input  logic                              i_clk      ,
    input  logic                              i_rst      ,
    input  logic                              i_pix_valid,
    input  logic                              i_vsync    ,
    input  logic                              i_mark_en  ,
    input  pixel565_u                         i_pixel    ,
    input  logic [$clog2(`AIMBOT_H_ACT)-1:0]  i_col      ,
    input  logic [$clog2(`AIMBOT_V_ACT)-1:0]  i_row      ,
    output logic                              o_de       ,
    output logic                              o_vsync    ,
    output logic [7:0]                        o_r        ,
    output logic [7:0]                        o_g        ,
    output logic [7:0]                        o_b
);

    localparam int COL_W = $clog2(`AIMBOT_H_ACT);
    localparam int ROW_W = $clog2(`AIMBOT_V_ACT);

    localparam logic [COL_W-1:0] MID_COL = COL_W'(`AIMBOT_H_ACT / 2);
    localparam logic [ROW_W-1:0] MID_ROW = ROW_W'(`AIMBOT_V_ACT / 2);

    logic [7:0] r8;
    logic [7:0] g8;
    logic [7:0] b8;
    logic       on_mark;

    // Bit repeat so full scale maps to FF
    assign r8 = {i_pixel.rgb.r5, i_pixel.rgb.r5[4:2]};
    assign g8 = {i_pixel.rgb.g6, i_pixel.rgb.g6[5:4]};
    assign b8 = {i_pixel.rgb.b5, i_pixel.rgb.b5[4:2]};

    // Centre row or centre column
    assign on_mark = i_mark_en & ((i_col == MID_COL) | (i_row == MID_ROW));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_de    <= 1'b0;
            o_vsync <= 1'b0;
        end else begin
            o_de    <= i_pix_valid;
            o_vsync <= i_vsync;
        end
    end

    always_ff @(posedge i_clk) begin
        o_r <= on_mark ? `AIMBOT_MARK_R : r8;
        o_g <= on_mark ? `AIMBOT_MARK_G : g8;
        o_b <= on_mark ? `AIMBOT_MARK_B : b8;
    end

endmodule : frame_marker

//--- design/cam_channel.sv
`timescale 1ns/100ps
`include "aimbot_settings.svh"

module cam_channel
    import aimbot_pkg::*;
(
    input  logic       i_clk     ,
    input  logic       i_rst     ,
    input  logic       i_vsync   ,
    input  logic       i_href    ,
    input  logic       i_mark_en ,
    input  logic [7:0] i_data    ,
    output logic       o_de      ,
    output logic       o_vsync   ,
    output logic       o_line_err,
    output logic [7:0] o_r       ,
    output logic [7:0] o_g       ,
    output logic [7:0] o_b
);

    logic                             pix_valid;
    logic                             vsync_d;
    pixel565_u                        pixel;
    logic [$clog2(`AIMBOT_H_ACT)-1:0] col;
    logic [$clog2(`AIMBOT_V_ACT)-1:0] row;

    cam_pixel_reader u_reader (
        .i_clk      (i_clk     ),
        .i_rst      (i_rst     ),
        .i_vsync    (i_vsync   ),
        .i_href     (i_href    ),
        .i_data     (i_data    ),
        .o_pix_valid(pix_valid ),
        .o_vsync_d  (vsync_d   ),
        .o_line_err (o_line_err),
        .o_pixel    (pixel     ),
        .o_col      (col       ),
        .o_row      (row       )
    );

    frame_marker u_marker (
        .i_clk      (i_clk     ),
        .i_rst      (i_rst     ),
        .i_pix_valid(pix_valid ),
        .i_vsync    (vsync_d   ),
        .i_mark_en  (i_mark_en ),
        .i_pixel    (pixel     ),
        .i_col      (col       ),
        .i_row      (row       ),
        .o_de       (o_de      ),
        .o_vsync    (o_vsync   ),
        .o_r        (o_r       ),
        .o_g        (o_g       ),
        .o_b        (o_b       )
    );

    // Pixels never leak into the vertical blank
    a_de_outside_vsync : assert property (
        @(posedge i_clk) disable iff (i_rst) o_de |-> !o_vsync);

endmodule : cam_channel

//--- design/view_switch.sv
`timescale 1ns/100ps

module view_switch (
    input  logic       i_clk       ,
    input  logic       i_rst       ,
    input  logic       i_cam_switch,
    input  logic       i_de1       ,
    input  logic       i_vsync1    ,
    input  logic       i_de2       ,
    input  logic       i_vsync2    ,
    input  logic [7:0] i_r1        ,
    input  logic [7:0] i_g1        ,
    input  logic [7:0] i_b1        ,
    input  logic [7:0] i_r2        ,
    input  logic [7:0] i_g2        ,
    input  logic [7:0] i_b2        ,
    output logic       o_de        ,
    output logic       o_vsync     ,
    output logic       o_cam_sel   ,
    output logic [7:0] o_r         ,
    output logic [7:0] o_g         ,
    output logic [7:0] o_b
);

    logic vsync1_d;
    logic vsync2_d;
    logic frame_start;
    logic de_sel;

    // Frame start of the camera on display
    assign frame_start = o_cam_sel ? (i_vsync2 & ~vsync2_d) : (i_vsync1 & ~vsync1_d);
    assign de_sel      = o_cam_sel ? i_de2 : i_de1;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vsync1_d  <= 1'b0;
            vsync2_d  <= 1'b0;
            o_cam_sel <= 1'b0;
            o_de      <= 1'b0;
            o_vsync   <= 1'b0;
            o_r       <= 8'h00;
            o_g       <= 8'h00;
            o_b       <= 8'h00;
        end else begin
            vsync1_d <= i_vsync1;
            vsync2_d <= i_vsync2;
            if (frame_start) begin
                o_cam_sel <= i_cam_switch;
            end
            o_de    <= de_sel;
            o_vsync <= o_cam_sel ? i_vsync2 : i_vsync1;
            // Blank colours outside active pixels
            o_r <= !de_sel ? 8'h00 : (o_cam_sel ? i_r2 : i_r1);
            o_g <= !de_sel ? 8'h00 : (o_cam_sel ? i_g2 : i_g1);
            o_b <= !de_sel ? 8'h00 : (o_cam_sel ? i_b2 : i_b1);
        end
    end

endmodule : view_switch

//--- design/aimbot_dual_cam.sv
`timescale 1ns/100ps

module aimbot_dual_cam (
    input  logic       i_clk          ,
    input  logic       i_rst          ,
    input  logic       i_cam_switch   ,
    input  logic       i_mark_en      ,

    input  logic       i_cam1_vsync   ,
    input  logic       i_cam1_href    ,
    input  logic [7:0] i_cam1_data    ,

    input  logic       i_cam2_vsync   ,
    input  logic       i_cam2_href    ,
    input  logic [7:0] i_cam2_data    ,

    output logic       o_hdmi_de      ,
    output logic       o_hdmi_vsync   ,
    output logic [7:0] o_hdmi_r       ,
    output logic [7:0] o_hdmi_g       ,
    output logic [7:0] o_hdmi_b       ,

    output logic       o_cam_sel      ,
    output logic       o_cam1_line_err,
    output logic       o_cam2_line_err
);

    logic       cam1_de, cam1_vsync;
    logic [7:0] cam1_r, cam1_g, cam1_b;
    logic       cam2_de, cam2_vsync;
    logic [7:0] cam2_r, cam2_g, cam2_b;

    cam_channel u_cam1_channel (
        .i_clk     (i_clk          ),
        .i_rst     (i_rst          ),
        .i_vsync   (i_cam1_vsync   ),
        .i_href    (i_cam1_href    ),
        .i_mark_en (i_mark_en      ),
        .i_data    (i_cam1_data    ),
        .o_de      (cam1_de        ),
        .o_vsync   (cam1_vsync     ),
        .o_line_err(o_cam1_line_err),
        .o_r       (cam1_r         ),
        .o_g       (cam1_g         ),
        .o_b       (cam1_b         )
    );

    cam_channel u_cam2_channel (
        .i_clk     (i_clk          ),
        .i_rst     (i_rst          ),
        .i_vsync   (i_cam2_vsync   ),
        .i_href    (i_cam2_href    ),
        .i_mark_en (i_mark_en      ),
        .i_data    (i_cam2_data    ),
        .o_de      (cam2_de        ),
        .o_vsync   (cam2_vsync     ),
        .o_line_err(o_cam2_line_err),
        .o_r       (cam2_r         ),
        .o_g       (cam2_g         ),
        .o_b       (cam2_b         )
    );

    view_switch u_view_switch (
        .i_clk       (i_clk       ),
        .i_rst       (i_rst       ),
        .i_cam_switch(i_cam_switch),
        .i_de1       (cam1_de     ),
        .i_vsync1    (cam1_vsync  ),
        .i_de2       (cam2_de     ),
        .i_vsync2    (cam2_vsync  ),
        .i_r1        (cam1_r      ),
        .i_g1        (cam1_g      ),
        .i_b1        (cam1_b      ),
        .i_r2        (cam2_r      ),
        .i_g2        (cam2_g      ),
        .i_b2        (cam2_b      ),
        .o_de        (o_hdmi_de   ),
        .o_vsync     (o_hdmi_vsync),
        .o_cam_sel   (o_cam_sel   ),
        .o_r         (o_hdmi_r    ),
        .o_g         (o_hdmi_g    ),
        .o_b         (o_hdmi_b    )
    );

endmodule : aimbot_dual_cam

//--- bench/tb_aimbot_dual_cam.sv
`timescale 1ns/100ps
`include "aimbot_settings.svh"

module tb_aimbot_dual_cam;

    localparam int H           = `AIMBOT_H_ACT;
    localparam int V           = `AIMBOT_V_ACT;
    localparam int VS_CYC      = 3;
    localparam int VG_CYC      = 4;
    localparam int HB_CYC      = 6;
    localparam int TAIL_CYC    = 2;
    localparam int N_FRAMES    = 6;
    localparam int CAM2_DELAY  = 5;
    localparam int SHORT_FRAME = 5;
    localparam int SHORT_LINE  = 3;
    localparam int SHORT_PX    = H / 2;
    localparam int FRAME_CYC   = VS_CYC + VG_CYC + V * (2 * H + HB_CYC) + TAIL_CYC;
    localparam int RUN_CYC     = 4 + CAM2_DELAY + N_FRAMES * FRAME_CYC + 12;
    localparam longint WATCHDOG_NS = 2 * RUN_CYC * 100;

    logic        i_clk = 1'b0;
    logic        i_rst, i_cam_switch, i_mark_en;
    logic        i_cam1_vsync, i_cam1_href, i_cam2_vsync, i_cam2_href;
    logic [7:0]  i_cam1_data, i_cam2_data;
    logic        o_hdmi_de, o_hdmi_vsync, o_cam_sel, o_cam1_line_err, o_cam2_line_err;
    logic [7:0]  o_hdmi_r, o_hdmi_g, o_hdmi_b;

    // Tags travel with each low byte so the model sees the same edge as the DUT
    logic        tag_valid1, tag_valid2;
    logic [23:0] tag_rgb1, tag_rgb2;
    logic [15:0] lfsr;
    string       test_name;
    string       frame_test [N_FRAMES] = '{"colour_path", "switch_request", "crosshair",
                                           "switch_back", "crosshair_cam1", "line_error"};

    // Display model state
    logic        sel_m, exp_de, exp_vsync;
    logic [2:0]  vh1, vh2;
    logic [1:0]  pv1, pv2;
    logic [23:0] pr1 [2];
    logic [23:0] pr2 [2];
    logic [23:0] exp_q [$];

    aimbot_dual_cam i_aimbot_dual_cam (.*);

    always #50 i_clk = ~i_clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] next_byte();
        logic [7:0] b;
        int i;
        b = 8'h00;
        for (i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return b;
    endfunction

    // Expected display colour of one camera pixel
    function automatic logic [23:0] ref_rgb(input logic [15:0] w, input int col, input int row,
                                             input logic mark);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = w[15:11];
        g = w[10:5];
        b = w[4:0];
        if (mark && (col == H / 2 || row == V / 2)) begin
            return {`AIMBOT_MARK_R, `AIMBOT_MARK_G, `AIMBOT_MARK_B};
        end
        return {r, r[4:2], g, g[5:4], b, b[4:2]};
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopping the run");
    endtask

    task automatic check_value(input string what, input logic [23:0] want, input logic [23:0] got);
        assert (got === want) else begin
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, want, got);
            $display("TEST FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    task automatic drive_cam(input int cam, input logic vs, input logic hr, input logic [7:0] d,
                             input logic tv, input logic [23:0] rgb);
        @(posedge i_clk);
        if (cam == 1) begin
            i_cam1_vsync <= vs;
            i_cam1_href  <= hr;
            i_cam1_data  <= d;
            tag_valid1   <= tv;
            tag_rgb1     <= rgb;
        end else begin
            i_cam2_vsync <= vs;
            i_cam2_href  <= hr;
            i_cam2_data  <= d;
            tag_valid2   <= tv;
            tag_rgb2     <= rgb;
        end
    endtask

    task automatic run_camera(input int cam);
        int f;
        int ln;
        int px;
        int n_px;
        logic [7:0] hi;
        logic [7:0] lo;
        logic mark;
        for (f = 0; f < N_FRAMES; f++) begin
            mark = (f >= 2);
            if (cam == 2 && f == SHORT_FRAME) begin
                @(negedge i_clk);
                assert (!o_cam1_line_err && !o_cam2_line_err)
                    else report_failure("A line error flag was set by well-formed frames");
            end
            drive_cam(cam, 1'b1, 1'b0, 8'h00, 1'b0, 24'h0);
            if (cam == 1) begin
                i_mark_en <= mark;
                test_name = frame_test[f];
            end
            repeat (VS_CYC - 1) drive_cam(cam, 1'b1, 1'b0, 8'h00, 1'b0, 24'h0);
            repeat (VG_CYC) drive_cam(cam, 1'b0, 1'b0, 8'h00, 1'b0, 24'h0);
            for (ln = 0; ln < V; ln++) begin
                n_px = (cam == 2 && f == SHORT_FRAME && ln == SHORT_LINE) ? SHORT_PX : H;
                for (px = 0; px < n_px; px++) begin
                    hi = next_byte();
                    lo = next_byte();
                    drive_cam(cam, 1'b0, 1'b1, hi, 1'b0, 24'h0);
                    // Mid-frame request, honoured at the next frame start
                    if (cam == 1 && (f == 1 || f == 3) && ln == V / 2 && px == 0) begin
                        i_cam_switch <= (f == 1);
                    end
                    drive_cam(cam, 1'b0, 1'b1, lo, 1'b1, ref_rgb({hi, lo}, px, ln, mark));
                end
                repeat (HB_CYC) drive_cam(cam, 1'b0, 1'b0, 8'h00, 1'b0, 24'h0);
            end
            repeat (TAIL_CYC) drive_cam(cam, 1'b0, 1'b0, 8'h00, 1'b0, 24'h0);
        end
    endtask

    // Switch stage sees pixels and vsync sampled two edges earlier
    always @(posedge i_clk) begin
        if (i_rst) begin
            sel_m     = 1'b0;
            exp_de    = 1'b0;
            exp_vsync = 1'b0;
            vh1       = 3'b000;
            vh2       = 3'b000;
            pv1       = 2'b00;
            pv2       = 2'b00;
        end else begin
            exp_de    = sel_m ? pv2[1] : pv1[1];
            exp_vsync = sel_m ? vh2[1] : vh1[1];
            if (exp_de) begin
                exp_q.push_back(sel_m ? pr2[1] : pr1[1]);
            end
            if (sel_m ? (vh2[1] && !vh2[2]) : (vh1[1] && !vh1[2])) begin
                sel_m = i_cam_switch;
            end
            vh1    = {vh1[1:0], i_cam1_vsync};
            vh2    = {vh2[1:0], i_cam2_vsync};
            pv1    = {pv1[0], tag_valid1};
            pv2    = {pv2[0], tag_valid2};
            pr1[1] = pr1[0];
            pr1[0] = tag_rgb1;
            pr2[1] = pr2[0];
            pr2[0] = tag_rgb2;
        end
    end

    always @(negedge i_clk) begin : compare
        logic [23:0] want;
        if (o_hdmi_de) begin
            assert (exp_q.size() > 0)
                else report_failure("A display pixel came out while none was expected");
            want = exp_q.pop_front();
            check_value("pixel", want, {o_hdmi_r, o_hdmi_g, o_hdmi_b});
        end else begin
            check_value("blank", 24'h0, {o_hdmi_r, o_hdmi_g, o_hdmi_b});
        end
        check_value("de", 24'(exp_de), 24'(o_hdmi_de));
        check_value("vsync", 24'(exp_vsync), 24'(o_hdmi_vsync));
        check_value("cam_sel", 24'(sel_m), 24'(o_cam_sel));
        if (i_rst) begin
            check_value("cam1_line_err", 24'h0, 24'(o_cam1_line_err));
            check_value("cam2_line_err", 24'h0, 24'(o_cam2_line_err));
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run took longer than %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        i_rst        = 1'b1;
        i_cam_switch = 1'b0;
        i_mark_en    = 1'b0;
        i_cam1_vsync = 1'b0;
        i_cam1_href  = 1'b0;
        i_cam1_data  = 8'h00;
        i_cam2_vsync = 1'b0;
        i_cam2_href  = 1'b0;
        i_cam2_data  = 8'h00;
        tag_valid1   = 1'b0;
        tag_valid2   = 1'b0;
        tag_rgb1     = 24'h0;
        tag_rgb2     = 24'h0;
        lfsr         = 16'd7628;
        test_name    = "reset";
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        fork
            run_camera(1);
            begin
                repeat (CAM2_DELAY) @(posedge i_clk);
                run_camera(2);
            end
        join
        repeat (8) @(posedge i_clk);
        @(negedge i_clk);
        test_name = "end_of_run";
        check_value("cam1_line_err", 24'h0, 24'(o_cam1_line_err));
        check_value("cam2_line_err", 24'h1, 24'(o_cam2_line_err));
        assert (exp_q.size() == 0) else report_failure("Expected pixels never reached the display");
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_aimbot_dual_cam

//--- list.f
+incdir+design
design/aimbot_pkg.sv
design/cam_pixel_reader.sv
design/frame_marker.sv
design/cam_channel.sv
design/view_switch.sv
design/aimbot_dual_cam.sv
bench/tb_aimbot_dual_cam.sv

//--- run.sh
#!/bin/sh
# Build and run the dual camera testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_aimbot_dual_cam \
    -Mdir obj_dir -o sim_aimbot
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_aimbot)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
